//--- Makefile
TOP := cache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+include
hw/ahb_pkg.sv
hw/cache_pkg.sv
hw/ahb_transfer_handler.sv
hw/cache_ctrl.sv
hw/cache_store.sv
hw/line_fill_master.sv
hw/cache_top.sv
verif/ahb_mem_model.sv
verif/cache_assert.sv
verif/cache_tb.sv

//--- hw/ahb_pkg.sv
package ahb_pkg;

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,
        TRANS_BUSY   = 2'b01,
        TRANS_NONSEQ = 2'b10,
        TRANS_SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BURST_SINGLE = 3'b000,
        BURST_INCR   = 3'b001,
        BURST_WRAP4  = 3'b010,
        BURST_INCR4  = 3'b011
    } hburst_t;

    localparam logic [2:0] SIZE_WORD = 3'b010; // 32-bit transfers only.

    typedef struct packed {
        logic [31:0] haddr;
        logic        hwrite;
        htrans_t     htrans;
        logic [2:0]  hsize;
        hburst_t     hburst;
        logic [31:0] hwdata;  // belongs to the data phase.
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_rsp_t;

endpackage

//--- hw/ahb_transfer_handler.sv
`timescale 1ns/1ps

module ahb_transfer_handler import ahb_pkg::*; import cache_pkg::*; (
    input  logic        hclk,
    input  logic        hrstn,
    input  ahb_req_t    up_req,
    output ahb_rsp_t    up_rsp,
    output cpu_op_t     op,
    input  cpu_result_t result
);

    logic        busy_q;        // a data phase is open.
    logic        issued_q;      // op already handed to the controller.
    logic        pend_write_q;
    logic [31:0] pend_addr_q;
    logic [31:0] rdata_q;
    logic        hready;
    logic        accept;

    // hit completes in the same cycle, so hready only drops on a miss or write.
    assign hready = !busy_q || result.done;
    assign accept = hready &&
                    (up_req.htrans == TRANS_NONSEQ || up_req.htrans == TRANS_SEQ);

    assign up_rsp.hready = hready;
    assign up_rsp.hresp  = 1'b0;
    assign up_rsp.hrdata = result.done ? result.rdata : rdata_q;

    assign op.valid = busy_q && !issued_q;
    assign op.write = pend_write_q;
    assign op.addr  = pend_addr_q;
    assign op.wdata = up_req.hwdata; // write data arrives with the data phase.

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            busy_q       <= 1'b0;
            issued_q     <= 1'b0;
            pend_write_q <= 1'b0;
        end else if (accept) begin
            busy_q       <= 1'b1;
            issued_q     <= 1'b0;
            pend_write_q <= up_req.hwrite;
        end else if (result.done) begin
            busy_q   <= 1'b0;
            issued_q <= 1'b0;
        end else if (op.valid) begin
            issued_q <= 1'b1;
        end
    end

    always_ff @(posedge hclk) begin
        if (accept)
            pend_addr_q <= up_req.haddr;
    end

    // keeps hrdata steady while the bus is stalled.
    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn)
            rdata_q <= '0;
        else if (result.done)
            rdata_q <= result.rdata;
    end

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                    hclk,
    input  logic                    hrstn,
    input  cpu_op_t                 op,
    output cpu_result_t             result,
    output logic [`INDEX_BITS-1:0]  rd_index,
    input  cache_entry_t            entry,
    output logic                    line_we,
    output cache_entry_t            line_wr,
    output logic                    word_we,
    output logic [`OFFSET_BITS-1:0] word_offset,
    output logic [`BUS_BITS-1:0]    word_data,
    output mem_cmd_t                cmd,
    input  mem_result_t             mem_res
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_WRITE
    } state_t;

    state_t               state_q;
    cache_addr_t          op_addr;
    cache_addr_t          cur_addr;
    cache_addr_t          look_addr;
    logic [`BUS_BITS-1:0] cur_wdata;
    logic                 hit;

    // line segment select.
    function automatic logic [`BUS_BITS-1:0] sel_word(
        input logic [`LINE_BITS-1:0]   line,
        input logic [`OFFSET_BITS-1:0] offset
    );
        return line[offset*`BUS_BITS +: `BUS_BITS];
    endfunction

    assign op_addr   = op.addr;
    assign look_addr = (state_q == ST_IDLE) ? op_addr : cur_addr;
    assign rd_index  = look_addr.index;
    assign hit       = entry.valid && (entry.tag == look_addr.tag);

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (op.valid && op.write)
                        state_q <= ST_WRITE;  // every write goes downstream.
                    else if (op.valid && !hit)
                        state_q <= ST_FILL;
                end
                ST_FILL, ST_WRITE: begin
                    if (mem_res.done)
                        state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge hclk) begin
        if (state_q == ST_IDLE && op.valid) begin
            cur_addr  <= op_addr;
            cur_wdata <= op.wdata;
        end
    end

    always_comb begin
        result    = '0;
        cmd       = '0;
        line_we   = 1'b0;
        word_we   = 1'b0;
        cmd.wdata = cur_wdata;
        case (state_q)
            ST_IDLE: begin
                if (op.valid && !op.write && hit) begin
                    result.done  = 1'b1;
                    result.rdata = sel_word(entry.line, look_addr.offset);
                end
            end
            ST_FILL: begin
                cmd.valid = 1'b1;
                cmd.fill  = 1'b1;
                cmd.addr  = {cur_addr.tag, cur_addr.index, {(`OFFSET_BITS + 2){1'b0}}};
                if (mem_res.done) begin
                    line_we      = 1'b1;
                    result.done  = 1'b1;
                    result.rdata = sel_word(mem_res.line, cur_addr.offset);
                end
            end
            ST_WRITE: begin
                cmd.valid = 1'b1;
                cmd.addr  = cur_addr;
                if (mem_res.done) begin
                    word_we     = hit;   // no allocate on a write miss.
                    result.done = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign line_wr.valid = 1'b1;
    assign line_wr.tag   = cur_addr.tag;
    assign line_wr.line  = mem_res.line;

    assign word_offset = cur_addr.offset;
    assign word_data   = cur_wdata;

endmodule

//--- hw/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    // word address split, byte field is ignored.
    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`INDEX_BITS-1:0]  index;
        logic [`OFFSET_BITS-1:0] offset;
        logic [1:0]              byte_sel;
    } cache_addr_t;

    typedef struct packed {
        logic                  valid;
        logic [`TAG_BITS-1:0]  tag;
        logic [`LINE_BITS-1:0] line;
    } cache_entry_t;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [31:0]          addr;
        logic [`BUS_BITS-1:0] wdata;
    } cpu_op_t;

    typedef struct packed {
        logic                 done;
        logic [`BUS_BITS-1:0] rdata;
    } cpu_result_t;

    typedef struct packed {
        logic                 valid;
        logic                 fill;   // 1 = line fill, 0 = single write.
        logic [31:0]          addr;
        logic [`BUS_BITS-1:0] wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic                  done;
        logic [`LINE_BITS-1:0] line;
    } mem_result_t;

endpackage

//--- hw/cache_store.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_store import cache_pkg::*; (
    input  logic                    hclk,
    input  logic                    hrstn,
    input  logic [`INDEX_BITS-1:0]  rd_index,
    output cache_entry_t            entry,
    input  logic                    line_we,
    input  cache_entry_t            line_wr,
    input  logic                    word_we,
    input  logic [`OFFSET_BITS-1:0] word_offset,
    input  logic [`BUS_BITS-1:0]    word_data
);

    logic                  valid_q [`LINES];
    logic [`TAG_BITS-1:0]  tag_q   [`LINES];
    logic [`LINE_BITS-1:0] line_q  [`LINES];

    // only the valid bits need clearing.
    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            for (int i = 0; i < `LINES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (line_we) begin
            valid_q[rd_index] <= line_wr.valid;
        end
    end

    // a line fill wins over a word update.
    always_ff @(posedge hclk) begin
        if (line_we) begin
            tag_q[rd_index]  <= line_wr.tag;
            line_q[rd_index] <= line_wr.line;
        end else if (word_we) begin
            line_q[rd_index][word_offset*`BUS_BITS +: `BUS_BITS] <= word_data;
        end
    end

    assign entry.valid = valid_q[rd_index];
    assign entry.tag   = tag_q[rd_index];
    assign entry.line  = line_q[rd_index];

endmodule

//--- hw/cache_top.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_top import ahb_pkg::*; import cache_pkg::*; (
    input  logic     hclk,
    input  logic     hrstn,
    input  ahb_req_t up_req,
    output ahb_rsp_t up_rsp,
    output ahb_req_t dn_req,
    input  ahb_rsp_t dn_rsp
);

    cpu_op_t                 op;
    cpu_result_t             result;
    logic [`INDEX_BITS-1:0]  rd_index;
    cache_entry_t            entry;
    logic                    line_we;
    cache_entry_t            line_wr;
    logic                    word_we;
    logic [`OFFSET_BITS-1:0] word_offset;
    logic [`BUS_BITS-1:0]    word_data;
    mem_cmd_t                cmd;
    mem_result_t             mem_res;

    ahb_transfer_handler u_handler (
        .hclk   (hclk),
        .hrstn  (hrstn),
        .up_req (up_req),
        .up_rsp (up_rsp),
        .op     (op),
        .result (result)
    );

    cache_ctrl u_ctrl (
        .hclk        (hclk),
        .hrstn       (hrstn),
        .op          (op),
        .result      (result),
        .rd_index    (rd_index),
        .entry       (entry),
        .line_we     (line_we),
        .line_wr     (line_wr),
        .word_we     (word_we),
        .word_offset (word_offset),
        .word_data   (word_data),
        .cmd         (cmd),
        .mem_res     (mem_res)
    );

    cache_store u_store (
        .hclk        (hclk),
        .hrstn       (hrstn),
        .rd_index    (rd_index),
        .entry       (entry),
        .line_we     (line_we),
        .line_wr     (line_wr),
        .word_we     (word_we),
        .word_offset (word_offset),
        .word_data   (word_data)
    );

    line_fill_master u_fill (
        .hclk    (hclk),
        .hrstn   (hrstn),
        .cmd     (cmd),
        .mem_res (mem_res),
        .dn_req  (dn_req),
        .dn_rsp  (dn_rsp)
    );

endmodule

//--- hw/line_fill_master.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module line_fill_master import ahb_pkg::*; import cache_pkg::*; (
    input  logic        hclk,
    input  logic        hrstn,
    input  mem_cmd_t    cmd,
    output mem_result_t mem_res,
    output ahb_req_t    dn_req,
    input  ahb_rsp_t    dn_rsp
);

    localparam int BEAT_BYTES = `BUS_BITS / 8;

    logic                  active_q;
    logic [2:0]            addr_cnt_q;  // address phases accepted.
    logic [1:0]            data_cnt_q;  // data phases completed.
    logic                  data_ph_q;
    logic                  done_q;
    logic [`LINE_BITS-1:0] line_q;
    logic [2:0]            beats;
    logic                  addr_on;
    logic                  addr_go;
    logic                  data_go;
    logic                  last_data;

    assign beats     = cmd.fill ? 3'(`BURST_BEATS) : 3'd1;
    assign addr_on   = active_q && (addr_cnt_q < beats);
    assign addr_go   = addr_on && dn_rsp.hready;
    assign data_go   = data_ph_q && dn_rsp.hready;
    assign last_data = ({1'b0, data_cnt_q} == beats - 3'd1);

    // address of beat n+1 overlaps the data phase of beat n.
    always_comb begin
        dn_req.htrans = TRANS_IDLE;
        if (addr_on)
            dn_req.htrans = (addr_cnt_q == 3'd0) ? TRANS_NONSEQ : TRANS_SEQ;
    end

    assign dn_req.haddr  = cmd.addr + 32'(addr_cnt_q) * BEAT_BYTES;
    assign dn_req.hwrite = !cmd.fill;
    assign dn_req.hsize  = SIZE_WORD;
    assign dn_req.hburst = cmd.fill ? BURST_INCR4 : BURST_SINGLE;
    assign dn_req.hwdata = cmd.wdata;

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            active_q   <= 1'b0;
            addr_cnt_q <= '0;
            data_cnt_q <= '0;
            data_ph_q  <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!active_q) begin
                if (cmd.valid && !done_q) begin  // cmd drops the cycle after done.
                    active_q   <= 1'b1;
                    addr_cnt_q <= '0;
                    data_cnt_q <= '0;
                end
            end else begin
                if (addr_go)
                    addr_cnt_q <= addr_cnt_q + 3'd1;
                if (addr_go)
                    data_ph_q <= 1'b1;
                else if (data_go)
                    data_ph_q <= 1'b0;
                if (data_go) begin
                    data_cnt_q <= data_cnt_q + 2'd1;
                    if (last_data) begin
                        active_q <= 1'b0;
                        done_q   <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (data_go && cmd.fill)
            line_q[data_cnt_q*`BUS_BITS +: `BUS_BITS] <= dn_rsp.hrdata;
    end

    assign mem_res.done = done_q;
    assign mem_res.line = line_q;

endmodule

//--- include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

`define CACHE_BYTES 1024
`define LINE_BITS   128
`define BUS_BITS    32
`define BURST_BEATS 4

// derived geometry.
`define LINES       (`CACHE_BYTES * 8 / `LINE_BITS)
`define INDEX_BITS  $clog2(`LINES)
`define OFFSET_BITS $clog2(`LINE_BITS / `BUS_BITS)
`define TAG_BITS    (32 - `INDEX_BITS - `OFFSET_BITS - 2)

`endif

//--- verif/ahb_mem_model.sv
`timescale 1ns/1ps

module ahb_mem_model import ahb_pkg::*; #(
    parameter int WORDS = 4096
) (
    input  logic     hclk,
    input  logic     hrstn,
    input  ahb_req_t req,
    output ahb_rsp_t rsp,
    output int       count
);

    localparam int         AW          = $clog2(WORDS);
    localparam logic [1:0] FIRST_WAITS = 2'd2;

    logic [31:0]   mem [WORDS];
    logic          dp_valid_q;
    logic          dp_write_q;
    logic [AW-1:0] dp_index_q;
    logic [1:0]    wait_q;
    logic          ready;
    logic          addr_valid;

    // power-up contents, a mix of every address bit.
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        logic [31:0] mix;
        mix = addr * 32'h9e37_79b1;
        return mix ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] peek(input logic [31:0] addr);
        return mem[addr[AW+1:2]];
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] <= init_word(32'(i) * 4);
        end
    end

    assign ready      = !dp_valid_q || (wait_q == 2'd0);
    assign addr_valid = (req.htrans == TRANS_NONSEQ) || (req.htrans == TRANS_SEQ);

    assign rsp.hready = ready;
    assign rsp.hresp  = 1'b0;
    assign rsp.hrdata = (dp_valid_q && !dp_write_q) ? mem[dp_index_q] : '0;

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            dp_valid_q <= 1'b0;
            dp_write_q <= 1'b0;
            dp_index_q <= '0;
            wait_q     <= '0;
            count      <= 0;
        end else if (!ready) begin
            wait_q <= wait_q - 2'd1;
        end else begin
            dp_valid_q <= addr_valid;
            dp_write_q <= req.hwrite;
            dp_index_q <= req.haddr[AW+1:2];
            wait_q     <= (req.htrans == TRANS_NONSEQ) ? FIRST_WAITS : 2'd0; // later beats run at full speed.
            if (addr_valid)
                count <= count + 1;
        end
    end

    always @(posedge hclk) begin
        if (ready && dp_valid_q && dp_write_q)
            mem[dp_index_q] <= req.hwdata;
    end

endmodule

//--- verif/cache_assert.sv
`timescale 1ns/1ps

module cache_assert import ahb_pkg::*; (
    input logic     hclk,
    input logic     hrstn,
    input ahb_rsp_t up_rsp,
    input ahb_req_t dn_req,
    input ahb_rsp_t dn_rsp
);

    logic dn_active;
    logic incr4_step;

    assign dn_active  = (dn_req.htrans == TRANS_NONSEQ) || (dn_req.htrans == TRANS_SEQ);
    // accepted beat of a line burst that is not the last one.
    assign incr4_step = dn_active && dn_rsp.hready && (dn_req.hburst == BURST_INCR4) &&
                        (dn_req.haddr[3:2] != 2'b11);

    up_hrdata_stable: assert property (@(posedge hclk) disable iff (!hrstn)
        (!up_rsp.hready && !$past(up_rsp.hready)) |-> $stable(up_rsp.hrdata))
        else $error("upstream hrdata changed during a wait state");

    dn_no_busy: assert property (@(posedge hclk) disable iff (!hrstn)
        dn_req.htrans != TRANS_BUSY)
        else $error("downstream master issued a BUSY transfer");

    dn_incr4_seq: assert property (@(posedge hclk) disable iff (!hrstn)
        incr4_step |=> (dn_req.htrans == TRANS_SEQ &&
                        dn_req.haddr == $past(dn_req.haddr) + 32'd4))
        else $error("INCR4 beat not followed by a SEQ beat at the next word");

    dn_hold: assert property (@(posedge hclk) disable iff (!hrstn)
        (dn_active && !dn_rsp.hready) |=> $stable(dn_req))
        else $error("downstream request changed while hready was low");

endmodule

bind cache_top cache_assert u_assert (
    .hclk   (hclk),
    .hrstn  (hrstn),
    .up_rsp (up_rsp),
    .dn_req (dn_req),
    .dn_rsp (dn_rsp)
);

//--- verif/cache_tb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb import ahb_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int MAX_XFERS      = 300;
    localparam int XFER_CYCLES    = 16; // a miss with two memory wait states needs about 12.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + MAX_XFERS * XFER_CYCLES;

    logic        hclk;
    logic        hrstn;
    ahb_req_t    up_req;
    ahb_rsp_t    up_rsp;
    ahb_req_t    dn_req;
    ahb_rsp_t    dn_rsp;
    int          dn_count;
    int          cycles = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [15:0] lfsr_q = 16'd79;
    logic [31:0] ref_mem [logic [31:0]]; // holds written words only.

    cache_top uut (
        .hclk   (hclk),
        .hrstn  (hrstn),
        .up_req (up_req),
        .up_rsp (up_rsp),
        .dn_req (dn_req),
        .dn_rsp (dn_rsp)
    );

    ahb_mem_model u_mem (
        .hclk  (hclk),
        .hrstn (hrstn),
        .req   (dn_req),
        .rsp   (dn_rsp),
        .count (dn_count)
    );

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;
    end

    always @(posedge hclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the cache stopped completing transfers", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // fibonacci lfsr with taps from x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        if (ref_mem.exists(addr))
            return ref_mem[addr];
        return u_mem.init_word(addr);
    endfunction

    task automatic drive_addr(input logic [31:0] addr, input logic write);
        up_req.haddr  = addr;
        up_req.hwrite = write;
        up_req.htrans = TRANS_NONSEQ;
        up_req.hsize  = SIZE_WORD;
        up_req.hburst = BURST_SINGLE;
    endtask

    task automatic drive_idle();
        up_req.htrans = TRANS_IDLE;
        up_req.hwrite = 1'b0;
    endtask

    // hready is sampled mid-cycle and the transfer moves on at the next rising edge.
    task automatic wait_ready(output ahb_rsp_t rsp, output int waits);
        waits = 0;
        @(negedge hclk);
        while (!up_rsp.hready) begin
            waits++;
            @(negedge hclk);
        end
        rsp = up_rsp;
        @(posedge hclk);
        #1;
    endtask

    task automatic ahb_read(input logic [31:0] addr, output ahb_rsp_t rsp, output int waits);
        ahb_rsp_t addr_rsp;
        drive_addr(addr, 1'b0);
        wait_ready(addr_rsp, waits);
        drive_idle();
        wait_ready(rsp, waits);
    endtask

    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
        ahb_rsp_t rsp;
        int       waits;
        drive_addr(addr, 1'b1);
        wait_ready(rsp, waits);
        drive_idle();
        up_req.hwdata = data;  // write data belongs to the data phase.
        wait_ready(rsp, waits);
        ref_mem[addr] = data;
    endtask

    task automatic check_word(input string what, input ahb_rsp_t got,
                              input logic [`BUS_BITS-1:0] exp);
        if (got.hrdata !== exp) begin
            $display("ERROR %0d ns: %s returned %h, expected %h",
                     $time, what, got.hrdata, exp);
            errors++;
        end
        if (got.hresp !== 1'b0) begin
            $display("ERROR %0d ns: %s responded with hresp %b, expected OKAY",
                     $time, what, got.hresp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_cold_miss();
        int       err0;
        int       base;
        int       waits;
        ahb_rsp_t rsp;
        err0 = errors;
        @(negedge hclk);
        check_count("hready after reset", int'(up_rsp.hready), 1);
        check_count("downstream htrans after reset", int'(dn_req.htrans), int'(TRANS_IDLE));
        @(posedge hclk);
        #1;
        base = dn_count;
        ahb_read(32'h40, rsp, waits);
        check_word("cold miss read", rsp, ref_read(32'h40));
        check_count("transfers for cold miss", dn_count - base, 4);
        report_test("cold_miss", err0);
    endtask

    task automatic test_line_hits();
        int          err0;
        int          base;
        int          waits;
        logic [31:0] a;
        ahb_rsp_t    rsp;
        err0 = errors;
        base = dn_count;
        for (int i = 0; i < 3; i++) begin
            a = 32'h44 + 32'(i) * 4;
            ahb_read(a, rsp, waits);
            check_word("line hit read", rsp, ref_read(a));
            check_count("line hit wait states", waits, 0);
        end
        // each address phase overlaps the data phase before it.
        drive_addr(32'h40, 1'b0);
        wait_ready(rsp, waits);
        for (int i = 1; i <= 4; i++) begin
            if (i < 4)
                drive_addr(32'h40 + 32'(i) * 4, 1'b0);
            else
                drive_idle();
            wait_ready(rsp, waits);
            a = 32'h40 + 32'(i - 1) * 4;
            check_word("back to back hit", rsp, ref_read(a));
            check_count("back to back hit wait states", waits, 0);
        end
        check_count("transfers during hits", dn_count - base, 0);
        report_test("line_hits", err0);
    endtask

    task automatic test_write_through();
        int       err0;
        int       base;
        int       waits;
        ahb_rsp_t rsp;
        ahb_rsp_t mem_word;
        err0 = errors;
        mem_word = '0;
        base = dn_count;
        ahb_write(32'h44, 32'h1234_5678);
        check_count("transfers for write hit", dn_count - base, 1);
        ahb_read(32'h44, rsp, waits);
        check_word("read after write hit", rsp, ref_read(32'h44));
        check_count("transfers after write hit read", dn_count - base, 1);
        mem_word.hrdata = u_mem.peek(32'h44);
        check_word("memory after write hit", mem_word, ref_read(32'h44));
        base = dn_count;
        ahb_write(32'h300, 32'hcafe_f00d); // index 0x30 is not cached yet.
        check_count("transfers for write miss", dn_count - base, 1);
        ahb_read(32'h300, rsp, waits);
        check_word("read after write miss", rsp, ref_read(32'h300));
        check_count("transfers after write miss read", dn_count - base, 5);
        report_test("write_through", err0);
    endtask

    task automatic test_conflict();
        int          err0;
        int          base;
        int          waits;
        logic [31:0] a;
        ahb_rsp_t    rsp;
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            a = (i % 2 == 1) ? 32'h480 : 32'h080; // same index with tags 1 and 0.
            base = dn_count;
            ahb_read(a, rsp, waits);
            check_word("conflict read", rsp, ref_read(a));
            check_count("transfers per conflict read", dn_count - base, 4);
        end
        report_test("conflict", err0);
    endtask

    task automatic test_random();
        int          err0;
        int          waits;
        logic [31:0] r;
        logic [31:0] a;
        logic        is_write;
        ahb_rsp_t    rsp;
        err0 = errors;
        for (int n = 0; n < 200; n++) begin
            r = rand_bits(1);
            is_write = r[0];
            r = rand_bits(10);
            a = {20'd0, r[9:0], 2'b00};  // word aligned inside 4 KB.
            if (is_write) begin
                ahb_write(a, rand_bits(32));
            end else begin
                ahb_read(a, rsp, waits);
                check_word("random read", rsp, ref_read(a));
            end
        end
        report_test("random", err0);
    endtask

    initial begin
        up_req = '0;
        hrstn  = 1'b0;
        repeat (RESET_CYCLES) @(posedge hclk);
        #1;
        hrstn = 1'b1;
        test_cold_miss();
        test_line_hits();
        test_write_through();
        test_conflict();
        test_random();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
